// ==== hdl/hpd_ctrl_defines.svh ====
/*
 * Geometry and field widths of the data-cache controller.
 * Included by the package and by the RTL files that size storage or slice addresses.
 */
`ifndef HPD_CTRL_DEFINES_SVH
`define HPD_CTRL_DEFINES_SVH

// Base geometry
`define HPD_ADDR_W          32
`define HPD_WORD_W          64
`define HPD_WORDS_PER_LINE  2
`define HPD_SETS            16
`define HPD_WAYS            2
`define HPD_TID_W           4

// Derived widths
`define HPD_BYTES_PER_WORD  (`HPD_WORD_W / 8)
`define HPD_OFFSET_W        ($clog2(`HPD_BYTES_PER_WORD))
`define HPD_WORD_IDX_W      ($clog2(`HPD_WORDS_PER_LINE))
`define HPD_SET_W           ($clog2(`HPD_SETS))
`define HPD_TAG_W           (`HPD_ADDR_W - `HPD_SET_W - `HPD_WORD_IDX_W - `HPD_OFFSET_W)

// Line number is the tag followed by the set index
`define HPD_NLINE_W         (`HPD_TAG_W + `HPD_SET_W)
`define HPD_LINE_W          (`HPD_WORD_W * `HPD_WORDS_PER_LINE)

`endif

// ==== hdl/hpd_ctrl_pkg.sv ====
/*
 * Types shared by the data-cache controller: request kind, address fields,
 * way vectors and data words. Imported by the RTL and by the testbench.
 */
`include "hpd_ctrl_defines.svh"

package hpd_ctrl_pkg;

    // Request kind
    typedef enum logic {
        HPD_OP_LOAD  = 1'b0,
        HPD_OP_STORE = 1'b1
    } hpd_op_e;

    // Address fields
    typedef logic [`HPD_TAG_W-1:0]      hpd_tag_t;
    typedef logic [`HPD_SET_W-1:0]      hpd_set_t;
    typedef logic [`HPD_WORD_IDX_W-1:0] hpd_word_idx_t;
    typedef logic [`HPD_NLINE_W-1:0]    hpd_nline_t;

    // Request bookkeeping
    typedef logic [`HPD_TID_W-1:0]      hpd_tid_t;

    // One bit per way, at most one set
    typedef logic [`HPD_WAYS-1:0]       hpd_way_vec_t;

    // Data
    typedef logic [`HPD_BYTES_PER_WORD-1:0] hpd_be_t;
    typedef logic [`HPD_LINE_W-1:0]         hpd_line_t;

    // A data word seen either whole or byte by byte
    typedef union packed {
        logic [`HPD_WORD_W-1:0]                 raw;
        logic [`HPD_BYTES_PER_WORD-1:0][7:0]    bytes;
    } hpd_word_u;

endpackage

// ==== hdl/hpd_rr_arb.sv ====
/*
 * Two-requester round-robin arbiter. The grant is combinational and the
 * priority token moves past the granted requester when ready_i is high.
 */
`timescale 1ns/1ps

module hpd_rr_arb (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic [1:0] req_i,
    output logic [1:0] gnt_o,
    input  logic       ready_i
);

    // Index of the requester holding priority
    logic prio_q;
    logic gnt_idx;

    // Token holder first, then the other one
    // With nothing requested the grant rests on the token holder
    always_comb begin
        if (req_i[prio_q]) begin
            gnt_idx = prio_q;
        end else if (req_i[~prio_q]) begin
            gnt_idx = ~prio_q;
        end else begin
            gnt_idx = prio_q;
        end
    end

    assign gnt_o = 2'b01 << gnt_idx;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= 1'b0;
        end else if (ready_i) begin
            // Next turn goes to the requester after the granted one
            prio_q <= ~gnt_idx;
        end
    end

endmodule

// ==== hdl/hpd_dir.sv ====
/*
 * Cache directory: valid bits and tags per way, one LRU bit per set.
 * The entries of the set read in stage 0 are registered and compared in
 * stage 1. Refills go to the LRU way, which is exported for the data array.
 */
`timescale 1ns/1ps
`include "hpd_ctrl_defines.svh"

module hpd_dir
    import hpd_ctrl_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,

    // Stage 0 read, stage 1 compare
    input  logic         read_i,
    input  hpd_set_t     read_set_i,
    input  hpd_tag_t     match_tag_i,
    output hpd_way_vec_t hit_way_o,
    input  logic         lru_updt_i,

    // Refill
    input  logic         refill_i,
    input  hpd_set_t     refill_set_i,
    input  hpd_tag_t     refill_tag_i,
    output hpd_way_vec_t hit_way_q_o
);

    // Directory storage
    logic [`HPD_SETS-1:0][`HPD_WAYS-1:0] valid_q;
    hpd_tag_t                            tag_q [`HPD_SETS][`HPD_WAYS];
    // Index of the least recently used way, per set
    logic [`HPD_SETS-1:0]                lru_q;

    // Entries of the set read in stage 0
    hpd_way_vec_t rd_valid_q;
    hpd_tag_t     rd_tag_q [`HPD_WAYS];
    hpd_set_t     rd_set_q;

    hpd_way_vec_t victim_way;

    // Refill victim taken from the LRU bit of the target set
    assign victim_way  = hpd_way_vec_t'(1) << lru_q[refill_set_i];
    assign hit_way_q_o = victim_way;

    // Tag compare against the registered entries
    always_comb begin
        for (int w = 0; w < `HPD_WAYS; w++) begin
            hit_way_o[w] = rd_valid_q[w] & (rd_tag_q[w] == match_tag_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            lru_q      <= '0;
            rd_valid_q <= '0;
        end else begin
            if (read_i) begin
                rd_valid_q <= valid_q[read_set_i];
            end
            if (refill_i) begin
                valid_q[refill_set_i] <= valid_q[refill_set_i] | victim_way;
                // Freshly filled way becomes most recent
                lru_q[refill_set_i]   <= ~lru_q[refill_set_i];
            end
            if (lru_updt_i) begin
                // Hit in way 0 leaves way 1 as least recent, and vice versa
                lru_q[rd_set_q] <= hit_way_o[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_i) begin
            rd_set_q <= read_set_i;
            for (int w = 0; w < `HPD_WAYS; w++) begin
                rd_tag_q[w] <= tag_q[read_set_i][w];
            end
        end
        if (refill_i) begin
            for (int w = 0; w < `HPD_WAYS; w++) begin
                if (victim_way[w]) begin
                    tag_q[refill_set_i][w] <= refill_tag_i;
                end
            end
        end
    end

endmodule

// ==== hdl/hpd_data_array.sv ====
/*
 * Data array of the cache. Stage 0 reads one word from every way; stage 1
 * picks the hit way. Stores merge bytes under a byte enable and refills
 * write a whole line into one way.
 */
`timescale 1ns/1ps
`include "hpd_ctrl_defines.svh"

module hpd_data_array
    import hpd_ctrl_pkg::*;
(
    input  logic          clk_i,

    // Read
    input  logic          read_i,
    input  hpd_set_t      read_set_i,
    input  hpd_word_idx_t read_word_i,
    output hpd_word_u     rdata_o,

    // Store, the way vector also selects the read word
    input  logic          write_i,
    input  hpd_way_vec_t  write_way_i,
    input  hpd_set_t      write_set_i,
    input  hpd_word_idx_t write_word_i,
    input  hpd_word_u     wdata_i,
    input  hpd_be_t       be_i,

    // Refill
    input  logic          refill_i,
    input  hpd_way_vec_t  refill_way_i,
    input  hpd_set_t      refill_set_i,
    input  hpd_line_t     refill_line_i
);

    hpd_word_u mem_q     [`HPD_SETS][`HPD_WAYS][`HPD_WORDS_PER_LINE];
    hpd_word_u rd_word_q [`HPD_WAYS];

    // Same word of every way, way chosen later
    always_ff @(posedge clk_i) begin
        if (read_i) begin
            for (int w = 0; w < `HPD_WAYS; w++) begin
                rd_word_q[w] <= mem_q[read_set_i][w][read_word_i];
            end
        end
    end

    // Late way mux, zero on a miss
    always_comb begin
        rdata_o = '0;
        for (int w = 0; w < `HPD_WAYS; w++) begin
            if (write_way_i[w]) begin
                rdata_o = rd_word_q[w];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `HPD_WAYS; w++) begin
            if (write_i && write_way_i[w]) begin
                for (int b = 0; b < `HPD_BYTES_PER_WORD; b++) begin
                    if (be_i[b]) begin
                        mem_q[write_set_i][w][write_word_i].bytes[b] <= wdata_i.bytes[b];
                    end
                end
            end
            // Word 0 sits in the low bits of the refill line
            if (refill_i && refill_way_i[w]) begin
                for (int k = 0; k < `HPD_WORDS_PER_LINE; k++) begin
                    mem_q[refill_set_i][w][k].raw <=
                        refill_line_i[k*`HPD_WORD_W +: `HPD_WORD_W];
                end
            end
        end
    end

endmodule

// ==== hdl/hpd_ctrl_pe.sv ====
/*
 * Protocol engine of the cache controller, purely combinational.
 * Applies the stage-0 stall rules and array reads, and turns the stage-1
 * hit and op into a store, an LRU update, a response or a miss.
 */
`timescale 1ns/1ps

module hpd_ctrl_pe
    import hpd_ctrl_pkg::*;
(
    // Stage 0 arbitration
    input  logic    core_valid_i,
    input  logic    core_gnt_i,
    input  logic    refill_valid_i,
    input  logic    refill_gnt_i,
    output logic    core_ready_o,
    output logic    refill_ready_o,
    output logic    arb_ready_o,

    // Stage 1
    input  logic    st1_valid_i,
    input  hpd_op_e st1_op_i,
    input  logic    st1_hit_i,
    input  logic    cfg_enable_i,
    output logic    st1_valid_o,
    output logic    dir_read_o,
    output logic    data_read_o,
    output logic    dir_lru_updt_o,
    output logic    data_write_o,
    output logic    rsp_valid_o,
    output logic    miss_o,
    output logic    refill_write_o
);

    logic st1_is_store;
    logic st1_cached_hit;
    logic core_take;
    logic refill_take;

    assign st1_is_store = st1_valid_i & (st1_op_i == HPD_OP_STORE);

    // A store in stage 1 writes at the next edge, so hold stage 0 one cycle
    assign core_ready_o = core_gnt_i & ~st1_is_store;
    assign core_take    = core_valid_i & core_ready_o;

    // Refills wait for an empty stage 1 and a free stage-0 slot
    assign refill_ready_o = refill_valid_i & refill_gnt_i & ~st1_valid_i & ~core_take;
    assign refill_take    = refill_valid_i & refill_ready_o;

    // Token moves on a consumed grant or on a grant nobody uses
    assign arb_ready_o = (core_gnt_i   & core_take)       |
                         (refill_gnt_i & refill_take)     |
                         (core_gnt_i   & ~core_valid_i)   |
                         (refill_gnt_i & ~refill_valid_i);

    // Stage 0 array reads, none with the cache off
    assign dir_read_o  = core_take & cfg_enable_i;
    assign data_read_o = core_take & cfg_enable_i;

    // Stage 1 always drains in one cycle
    assign st1_valid_o = core_take;

    // Disabled cache forces the miss path
    assign st1_cached_hit = st1_valid_i & st1_hit_i & cfg_enable_i;

    assign rsp_valid_o    = st1_cached_hit & (st1_op_i == HPD_OP_LOAD);
    assign data_write_o   = st1_cached_hit & (st1_op_i == HPD_OP_STORE);
    assign dir_lru_updt_o = st1_cached_hit;
    assign miss_o         = st1_valid_i & ~st1_cached_hit;

    // Refill still accepted when disabled so the miss handler drains
    assign refill_write_o = refill_take & cfg_enable_i;

endmodule

// ==== hdl/hpd_ctrl.sv ====
/*
 * Two-stage data-cache controller. Core requests and refills share the
 * stage-0 slot through a round-robin arbiter; stage 1 resolves hit or miss
 * and drives the response and the miss strobe.
 */
`timescale 1ns/1ps
`include "hpd_ctrl_defines.svh"

module hpd_ctrl
    import hpd_ctrl_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // Core request
    input  logic                   core_req_valid_i,
    output logic                   core_req_ready_o,
    input  logic [`HPD_ADDR_W-1:0] core_req_addr_i,
    input  hpd_op_e                core_req_op_i,
    input  hpd_word_u              core_req_wdata_i,
    input  hpd_be_t                core_req_be_i,
    input  hpd_tid_t               core_req_tid_i,

    // Core response
    output logic                   core_rsp_valid_o,
    output hpd_word_u              core_rsp_rdata_o,
    output hpd_tid_t               core_rsp_tid_o,

    // Miss strobe
    output logic                   miss_valid_o,
    output hpd_nline_t             miss_nline_o,
    output hpd_tid_t               miss_tid_o,

    // Refill from the miss handler
    input  logic                   refill_valid_i,
    output logic                   refill_ready_o,
    input  hpd_nline_t             refill_nline_i,
    input  hpd_line_t              refill_data_i,

    input  logic                   cfg_enable_i,
    output logic                   ctrl_empty_o
);

    // Stage 0 address fields
    hpd_tag_t      st0_tag;
    hpd_set_t      st0_set;
    hpd_word_idx_t st0_word;

    // Stage 1 registers
    logic          st1_valid_q;
    hpd_tag_t      st1_tag_q;
    hpd_set_t      st1_set_q;
    hpd_word_idx_t st1_word_q;
    hpd_op_e       st1_op_q;
    hpd_word_u     st1_wdata_q;
    hpd_be_t       st1_be_q;
    hpd_tid_t      st1_tid_q;

    logic [1:0]    arb_req;
    logic [1:0]    arb_gnt;
    logic          arb_ready;

    logic          st1_valid_d;
    logic          dir_read;
    logic          data_read;
    logic          lru_updt;
    logic          data_write;
    logic          refill_write;
    hpd_way_vec_t  st1_hit_way;
    hpd_way_vec_t  refill_way;
    hpd_set_t      refill_set;
    hpd_tag_t      refill_tag;
    hpd_word_u     st1_rdata;

    assign st0_tag  = core_req_addr_i[`HPD_ADDR_W-1 -: `HPD_TAG_W];
    assign st0_set  = core_req_addr_i[`HPD_OFFSET_W + `HPD_WORD_IDX_W +: `HPD_SET_W];
    assign st0_word = core_req_addr_i[`HPD_OFFSET_W +: `HPD_WORD_IDX_W];

    assign refill_set = refill_nline_i[`HPD_SET_W-1:0];
    assign refill_tag = refill_nline_i[`HPD_NLINE_W-1 -: `HPD_TAG_W];

    // Requester 0 is the core, 1 the refill
    assign arb_req = {refill_valid_i, core_req_valid_i};

    hpd_rr_arb st0_arb (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (arb_req),
        .gnt_o   (arb_gnt),
        .ready_i (arb_ready)
    );

    hpd_ctrl_pe ctrl_pe (
        .core_valid_i   (core_req_valid_i),
        .core_gnt_i     (arb_gnt[0]),
        .refill_valid_i (refill_valid_i),
        .refill_gnt_i   (arb_gnt[1]),
        .core_ready_o   (core_req_ready_o),
        .refill_ready_o (refill_ready_o),
        .arb_ready_o    (arb_ready),
        .st1_valid_i    (st1_valid_q),
        .st1_op_i       (st1_op_q),
        .st1_hit_i      (|st1_hit_way),
        .cfg_enable_i   (cfg_enable_i),
        .st1_valid_o    (st1_valid_d),
        .dir_read_o     (dir_read),
        .data_read_o    (data_read),
        .dir_lru_updt_o (lru_updt),
        .data_write_o   (data_write),
        .rsp_valid_o    (core_rsp_valid_o),
        .miss_o         (miss_valid_o),
        .refill_write_o (refill_write)
    );

    hpd_dir dir (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .read_i       (dir_read),
        .read_set_i   (st0_set),
        .match_tag_i  (st1_tag_q),
        .hit_way_o    (st1_hit_way),
        .lru_updt_i   (lru_updt),
        .refill_i     (refill_write),
        .refill_set_i (refill_set),
        .refill_tag_i (refill_tag),
        .hit_way_q_o  (refill_way)
    );

    hpd_data_array data_array (
        .clk_i         (clk_i),
        .read_i        (data_read),
        .read_set_i    (st0_set),
        .read_word_i   (st0_word),
        .rdata_o       (st1_rdata),
        .write_i       (data_write),
        .write_way_i   (st1_hit_way),
        .write_set_i   (st1_set_q),
        .write_word_i  (st1_word_q),
        .wdata_i       (st1_wdata_q),
        .be_i          (st1_be_q),
        .refill_i      (refill_write),
        .refill_way_i  (refill_way),
        .refill_set_i  (refill_set),
        .refill_line_i (refill_data_i)
    );

    // Payload follows every accepted core request
    always_ff @(posedge clk_i) begin
        if (st1_valid_d) begin
            st1_tag_q   <= st0_tag;
            st1_set_q   <= st0_set;
            st1_word_q  <= st0_word;
            st1_op_q    <= core_req_op_i;
            st1_wdata_q <= core_req_wdata_i;
            st1_be_q    <= core_req_be_i;
            st1_tid_q   <= core_req_tid_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            st1_valid_q <= 1'b0;
        end else begin
            st1_valid_q <= st1_valid_d;
        end
    end

    assign core_rsp_rdata_o = st1_rdata;
    assign core_rsp_tid_o   = st1_tid_q;

    assign miss_nline_o = {st1_tag_q, st1_set_q};
    assign miss_tid_o   = st1_tid_q;

    assign ctrl_empty_o = ~st1_valid_q;

endmodule

// ==== bench/hpd_ctrl_tb.sv ====
/*
 * Testbench of the data-cache controller. Loads and stores from an LCG run
 * against a cache model, while a miss-handler model answers misses with refills.
 * Directed sequences cover refill, store merge, eviction and the disabled cache.
 */
`timescale 1ns/1ps

module hpd_ctrl_tb
    import hpd_ctrl_pkg::*;
();

    localparam int TIMEOUT = 64;

    logic        clk;
    logic        rst_n;
    logic        core_req_valid;
    logic        core_req_ready;
    logic [31:0] core_req_addr;
    hpd_op_e     core_req_op;
    hpd_word_u   core_req_wdata;
    hpd_be_t     core_req_be;
    hpd_tid_t    core_req_tid;
    logic        core_rsp_valid;
    hpd_word_u   core_rsp_rdata;
    hpd_tid_t    core_rsp_tid;
    logic        miss_valid;
    hpd_nline_t  miss_nline;
    hpd_tid_t    miss_tid;
    logic        refill_valid;
    logic        refill_ready;
    hpd_nline_t  refill_nline;
    hpd_line_t   refill_data;
    logic        cfg_enable;
    logic        ctrl_empty;

    // Cache model, indexed by set and way
    logic        m_valid [16][2];
    hpd_tag_t    m_tag   [16][2];
    logic        m_lru   [16];
    logic [63:0] m_data  [16][2][2];

    // Expected stage-1 outcome of the last accepted request
    logic        exp_miss;
    logic [63:0] exp_rdata;
    hpd_nline_t  exp_nline;
    hpd_op_e     exp_op;
    hpd_tid_t    exp_tid;

    // Miss handler pending lines and the cycle each refill is due
    hpd_nline_t  pend_q [$];
    int          due_q  [$];

    logic [31:0] lcg_state;
    int          cycle;
    int          refill_wait;
    logic        core_passed;
    logic        refill_passed;
    logic        last_miss;
    logic        st1_full;
    string       phase;

    hpd_ctrl dut0 (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .core_req_valid_i (core_req_valid),
        .core_req_ready_o (core_req_ready),
        .core_req_addr_i  (core_req_addr),
        .core_req_op_i    (core_req_op),
        .core_req_wdata_i (core_req_wdata),
        .core_req_be_i    (core_req_be),
        .core_req_tid_i   (core_req_tid),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_rdata_o (core_rsp_rdata),
        .core_rsp_tid_o   (core_rsp_tid),
        .miss_valid_o     (miss_valid),
        .miss_nline_o     (miss_nline),
        .miss_tid_o       (miss_tid),
        .refill_valid_i   (refill_valid),
        .refill_ready_o   (refill_ready),
        .refill_nline_i   (refill_nline),
        .refill_data_i    (refill_data),
        .cfg_enable_i     (cfg_enable),
        .ctrl_empty_o     (ctrl_empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper LCG bits reduced to 0..n-1
    function automatic int rand_below(int n);
        return int'(lcg_next() >> 16) % n;
    endfunction

    // Refill pattern from line number and word index
    function automatic logic [63:0] fill_word(hpd_nline_t nline, int k);
        return {nline, 3'(k), ~nline, 5'b10101};
    endfunction

    // Tag from a pool of four, then set, word and a zero byte offset
    function automatic logic [31:0] make_addr(int tag_sel, int set, int word);
        return {24'hC0DE00 + 24'(tag_sel), 4'(set), 1'(word), 3'b000};
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(string name, logic [127:0] exp, logic [127:0] act);
        if (exp !== act) begin
            stop_run($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    // Predicts the request accepted at this edge and updates the model in acceptance order
    task automatic predict_core();
        hpd_tag_t tag;
        hpd_set_t set;
        int       word;
        int       hit;
        tag  = core_req_addr[31:8];
        set  = core_req_addr[7:4];
        word = int'(core_req_addr[3]);
        hit  = -1;
        if (cfg_enable) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[set][w] && m_tag[set][w] == tag) begin
                    hit = w;
                end
            end
        end
        exp_miss  = (hit < 0);
        exp_nline = {tag, set};
        exp_op    = core_req_op;
        exp_tid   = core_req_tid;
        if (hit >= 0) begin
            // Other way becomes least recent
            m_lru[set] = (hit == 0);
            exp_rdata  = m_data[set][hit][word];
            if (core_req_op == HPD_OP_STORE) begin
                for (int b = 0; b < 8; b++) begin
                    if (core_req_be[b]) begin
                        m_data[set][hit][word][b*8 +: 8] = core_req_wdata.raw[b*8 +: 8];
                    end
                end
            end
        end
    endtask

    // Refill lands in the LRU way, which then becomes most recent
    task automatic apply_refill();
        hpd_set_t set;
        int       way;
        set = refill_nline[3:0];
        way = int'(m_lru[set]);
        if (cfg_enable) begin
            m_valid[set][way]   = 1'b1;
            m_tag[set][way]     = refill_nline[27:4];
            m_data[set][way][0] = fill_word(refill_nline, 0);
            m_data[set][way][1] = fill_word(refill_nline, 1);
            m_lru[set]          = (way == 0);
        end
    endtask

    task automatic check_outputs(logic core_fire);
        logic want_rsp;
        logic want_miss;
        want_miss = core_fire && exp_miss;
        want_rsp  = core_fire && !exp_miss && exp_op == HPD_OP_LOAD;
        check_eq({phase, " ctrl_empty"}, !core_fire, ctrl_empty);
        check_eq({phase, " miss_valid"}, want_miss, miss_valid);
        check_eq({phase, " rsp_valid"}, want_rsp, core_rsp_valid);
        if (want_miss) begin
            check_eq({phase, " miss_nline"}, exp_nline, miss_nline);
            check_eq({phase, " miss_tid"}, exp_tid, miss_tid);
        end
        if (want_rsp) begin
            check_eq({phase, " rsp_rdata"}, exp_rdata, core_rsp_rdata.raw);
            check_eq({phase, " rsp_tid"}, exp_tid, core_rsp_tid);
        end
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic step();
        logic core_fire;
        logic refill_fire;
        logic dup;
        #1;
        // Stage 1 busy blocks refills, a store there blocks the core
        if (st1_full) begin
            check_eq({phase, " refill_ready_busy"}, 0, refill_ready);
            if (exp_op == HPD_OP_STORE) begin
                check_eq({phase, " core_ready_store"}, 0, core_req_ready);
            end
        end
        core_fire   = core_req_valid && core_req_ready;
        refill_fire = refill_valid && refill_ready;
        if (core_fire) begin
            predict_core();
        end
        if (refill_fire) begin
            apply_refill();
        end
        // A pending requester never loses two grants in a row
        if (core_fire && refill_valid) begin
            check_eq({phase, " arb_core_twice"}, 0, core_passed);
            core_passed = 1'b1;
        end
        if (refill_fire && core_req_valid) begin
            check_eq({phase, " arb_refill_twice"}, 0, refill_passed);
            refill_passed = 1'b1;
        end
        if (core_fire) begin
            refill_passed = 1'b0;
        end
        if (refill_fire) begin
            core_passed = 1'b0;
        end
        refill_wait = (refill_valid && !refill_fire) ? refill_wait + 1 : 0;
        if (refill_wait > TIMEOUT) begin
            stop_run("refill was not accepted within the timeout");
        end
        @(posedge clk);
        @(negedge clk);
        cycle++;
        check_outputs(core_fire);
        st1_full  = core_fire;
        last_miss = core_fire && exp_miss;
        if (core_fire) begin
            core_req_valid = 1'b0;
        end
        if (refill_fire) begin
            refill_valid = 1'b0;
            void'(pend_q.pop_front());
            void'(due_q.pop_front());
        end
        // Each missed line is refilled once and a few cycles later
        if (last_miss && cfg_enable) begin
            dup = 1'b0;
            foreach (pend_q[i]) begin
                if (pend_q[i] == exp_nline) begin
                    dup = 1'b1;
                end
            end
            if (!dup) begin
                pend_q.push_back(exp_nline);
                due_q.push_back(cycle + 1 + rand_below(8));
            end
        end
        if (!refill_valid && pend_q.size() != 0 && due_q[0] <= cycle) begin
            refill_valid = 1'b1;
            refill_nline = pend_q[0];
            refill_data  = {fill_word(pend_q[0], 1), fill_word(pend_q[0], 0)};
        end
    endtask

    // Holds one core request until it is accepted
    task automatic issue(hpd_op_e op, logic [31:0] addr, logic [63:0] wdata, hpd_be_t be);
        int waited;
        core_req_valid     = 1'b1;
        core_req_op        = op;
        core_req_addr      = addr;
        core_req_wdata.raw = wdata;
        core_req_be        = be;
        core_req_tid       = core_req_tid + 1'b1;
        waited = 0;
        while (core_req_valid) begin
            if (waited > TIMEOUT) begin
                stop_run("core request was not accepted within the timeout");
            end
            step();
            waited++;
        end
    endtask

    // Empties stage 1, then waits until every refill is taken
    task automatic drain();
        int waited;
        waited = 0;
        step();
        while (pend_q.size() != 0) begin
            if (waited > 4 * TIMEOUT) begin
                stop_run("pending refills did not drain within the timeout");
            end
            step();
            waited++;
        end
    endtask

    task automatic random_run(int count);
        hpd_op_e     op;
        int          tag_sel;
        int          set;
        int          word;
        logic [63:0] wdata;
        hpd_be_t     be;
        for (int i = 0; i < count; i++) begin
            op      = (rand_below(3) == 0) ? HPD_OP_STORE : HPD_OP_LOAD;
            tag_sel = rand_below(4);
            set     = rand_below(16);
            word    = rand_below(2);
            wdata   = {lcg_next(), lcg_next()};
            be      = hpd_be_t'(lcg_next() >> 8);
            issue(op, make_addr(tag_sel, set, word), wdata, be);
            if (rand_below(4) == 0) begin
                step();
            end
        end
    endtask

    initial begin
        rst_n              = 1'b0;
        core_req_valid     = 1'b0;
        core_req_addr      = '0;
        core_req_op        = HPD_OP_LOAD;
        core_req_wdata.raw = '0;
        core_req_be        = '0;
        core_req_tid       = '0;
        refill_valid       = 1'b0;
        refill_nline       = '0;
        refill_data        = '0;
        cfg_enable         = 1'b1;
        lcg_state          = 32'd75851;
        cycle              = 0;
        refill_wait        = 0;
        core_passed        = 1'b0;
        refill_passed      = 1'b0;
        last_miss          = 1'b0;
        st1_full           = 1'b0;
        for (int s = 0; s < 16; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
            end
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        phase = "reset";
        check_eq({phase, " ctrl_empty"}, 1, ctrl_empty);
        check_eq({phase, " rsp_valid"}, 0, core_rsp_valid);
        check_eq({phase, " miss_valid"}, 0, miss_valid);
        check_eq({phase, " refill_ready"}, 0, refill_ready);

        phase = "load_miss_refill";
        issue(HPD_OP_LOAD, make_addr(0, 3, 1), '0, '0);
        check_eq({phase, " first_load_miss"}, 1, miss_valid);
        drain();
        issue(HPD_OP_LOAD, make_addr(0, 3, 1), '0, '0);
        check_eq({phase, " reload_hit"}, 1, core_rsp_valid);

        // Partial store into a filled line, then a store miss without allocation
        phase = "store_merge";
        issue(HPD_OP_STORE, make_addr(0, 3, 1), 64'h1122334455667788, 8'b1010_0101);
        issue(HPD_OP_LOAD, make_addr(0, 3, 1), '0, '0);
        issue(HPD_OP_STORE, make_addr(1, 9, 0), 64'hFFFF_FFFF_FFFF_FFFF, 8'hFF);
        check_eq({phase, " store_miss"}, 1, miss_valid);
        drain();
        issue(HPD_OP_LOAD, make_addr(1, 9, 0), '0, '0);

        phase = "lru_evict";
        issue(HPD_OP_LOAD, make_addr(0, 5, 0), '0, '0);
        issue(HPD_OP_LOAD, make_addr(1, 5, 0), '0, '0);
        drain();
        issue(HPD_OP_LOAD, make_addr(0, 5, 0), '0, '0);
        issue(HPD_OP_LOAD, make_addr(2, 5, 0), '0, '0);
        drain();
        issue(HPD_OP_LOAD, make_addr(1, 5, 0), '0, '0);
        check_eq({phase, " evicted_miss"}, 1, miss_valid);
        issue(HPD_OP_LOAD, make_addr(0, 5, 0), '0, '0);
        check_eq({phase, " survivor_hit"}, 1, core_rsp_valid);
        drain();

        phase = "random";
        random_run(300);
        drain();

        phase = "cache_disabled";
        cfg_enable = 1'b0;
        random_run(40);
        drain();

        phase = "random_reenabled";
        cfg_enable = 1'b1;
        random_run(200);
        drain();

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== hpd_ctrl.f ====
+incdir+hdl
hdl/hpd_ctrl_pkg.sv
hdl/hpd_rr_arb.sv
hdl/hpd_dir.sv
hdl/hpd_data_array.sv
hdl/hpd_ctrl_pe.sv
hdl/hpd_ctrl.sv
bench/hpd_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cache controller testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module hpd_ctrl_tb \
    -f hpd_ctrl.f \
    -o hpd_ctrl_sim

# The simulator exit status is not trusted, the log decides
./obj_dir/hpd_ctrl_sim | tee sim.log || true

if grep -q "NO ERRORS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
